/* src/rv_pkg.sv */
// rv32i integer subset only (no jal/jalr, no byte or half access), memories are word addressed
package rv_pkg;

	// --------------------
	// widths and constants
	localparam int xlen       = 32;
	localparam int addr_w     = 30;	// word address, byte offset dropped
	localparam int reg_addr_w = 5;

	localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;	// addi x0,x0,0

	// --------------------
	// encodings
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,	// add sub and or xor slt
		op_imm    = 7'b0010011,	// addi andi ori xori slti slli srli srai
		op_load   = 7'b0000011,	// lw only
		op_store  = 7'b0100011,	// sw only
		op_branch = 7'b1100011	// beq bne
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,	// signed
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op_e;

	// --------------------
	// stage payloads
	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic alu_src_imm;	// operand b from imm, else rs2
		logic is_beq;
		logic is_bne;
	} ctrl_t;	// all zero means bubble

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		alu_op_e               alu_op;
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       rs1_data;
		logic [xlen-1:0]       rs2_data;
		logic [xlen-1:0]       imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       alu_result;	// also the byte address for lw/sw
		logic [xlen-1:0]       store_data;
	} ex_mem_t;

	typedef struct packed {
		logic                  reg_write;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       data;
	} wb_t;	// regfile write port and last forwarding source

	typedef struct packed {
		logic            taken;
		logic [xlen-1:0] target;	// byte address
	} redirect_t;

endpackage

/* src/fetch_stage.sv */
// imem_rdata must return the word at imem_addr one edge later, the first cycle after reset refetches 0
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
	input  logic              clk,
	input  logic              proc_reset,
	input  logic              stall,	// load-use hold from decode
	input  redirect_t         redirect,
	output logic [addr_w-1:0] imem_addr,
	input  logic [xlen-1:0]   imem_rdata,
	output if_id_t            if_id
);

	logic [xlen-1:0] pc_q;
	logic [xlen-1:0] pc_next;
	logic            live_q;	// low until imem_rdata matches pc_q

	// next address, redirect wins over the hold
	always_comb begin
		if (redirect.taken)
			pc_next = redirect.target;
		else if (stall || !live_q)
			pc_next = pc_q;	// hold, same word comes back
		else
			pc_next = pc_q + 32'd4;
	end

	assign imem_addr = pc_next[xlen-1:2];	// so the word lands with pc_q

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			pc_q        <= '0;
			live_q      <= 1'b0;
			if_id.pc    <= '0;
			if_id.instr <= nop_instr;
		end else begin
			live_q <= 1'b1;
			pc_q   <= pc_next;
			if (redirect.taken || !live_q) begin
				if_id.pc    <= pc_q;
				if_id.instr <= nop_instr;	// squash wrong-path / stale word
			end else if (!stall) begin
				if_id.pc    <= pc_q;
				if_id.instr <= imem_rdata;
			end
		end
	end

endmodule

/* src/decode_stage.sv */
// regfile writes at the wb edge with same-cycle bypass, unsupported opcodes decode as bubbles
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
	input  logic      clk,
	input  logic      proc_reset,
	input  if_id_t    if_id,
	input  wb_t       wb,
	input  redirect_t redirect,
	output logic      stall,
	output id_ex_t    id_ex
);

	logic [xlen-1:0] regs [2**reg_addr_w];

	opcode_e               opcode;
	logic [2:0]            funct3;
	logic                  funct7_b5;	// sub / sra select
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;
	logic                  uses_rs2;
	ctrl_t                 ctrl;
	alu_op_e               alu_op;
	logic [xlen-1:0]       imm;
	logic                  kill;
	id_ex_t                id_ex_next;

	// instruction fields
	assign opcode    = opcode_e'(if_id.instr[6:0]);
	assign rd        = if_id.instr[11:7];
	assign funct3    = if_id.instr[14:12];
	assign rs1       = if_id.instr[19:15];
	assign rs2       = if_id.instr[24:20];
	assign funct7_b5 = if_id.instr[30];

	// --------------------
	// register file
	always_ff @(posedge clk) begin
		if (wb.reg_write && wb.rd != '0)
			regs[wb.rd] <= wb.data;	// x0 never written
	end

	// x0 reads zero, wb bypass covers the write in this same cycle
	assign rs1_data = (rs1 == '0) ? '0 :
		(wb.reg_write && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 :
		(wb.reg_write && wb.rd == rs2) ? wb.data : regs[rs2];

	// --------------------
	// control and immediate
	always_comb begin
		ctrl = '0;
		imm  = '0;
		case (opcode)
			op_reg: ctrl.reg_write = 1'b1;
			op_imm: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				// shifts only look at imm[4:0], so srai's funct7 bit is harmless
				imm = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
			end
			op_load: begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
			end
			op_store: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
			end
			op_branch: begin
				ctrl.is_beq = (funct3 == 3'b000);
				ctrl.is_bne = (funct3 == 3'b001);
				imm = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
					if_id.instr[30:25], if_id.instr[11:8], 1'b0};	// b-type offset
			end
			default: ctrl = '0;	// anything else is a nop
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  alu_op = (opcode == op_reg && funct7_b5) ? alu_sub : alu_add;
			3'b001:  alu_op = alu_sll;
			3'b010:  alu_op = alu_slt;
			3'b100:  alu_op = alu_xor;
			3'b101:  alu_op = funct7_b5 ? alu_sra : alu_srl;
			3'b110:  alu_op = alu_or;
			3'b111:  alu_op = alu_and;
			default: alu_op = alu_add;
		endcase
		if (opcode != op_reg && opcode != op_imm)
			alu_op = alu_add;	// lw/sw address, branch result unused
	end

	// --------------------
	// load-use hazard, one bubble while the load moves to mem
	assign uses_rs2 = (opcode == op_reg) || (opcode == op_store) || (opcode == op_branch);
	assign stall = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
		(id_ex.rd == rs1 || (uses_rs2 && id_ex.rd == rs2));

	assign kill = stall || redirect.taken;	// branch in ex flushes this slot too

	always_comb begin
		id_ex_next.ctrl     = kill ? ctrl_t'('0) : ctrl;
		id_ex_next.alu_op   = alu_op;
		id_ex_next.pc       = if_id.pc;
		id_ex_next.rs1      = rs1;
		id_ex_next.rs2      = rs2;
		id_ex_next.rd       = rd;
		id_ex_next.rs1_data = rs1_data;
		id_ex_next.rs2_data = rs2_data;
		id_ex_next.imm      = imm;
	end

	always_ff @(posedge clk) begin
		if (proc_reset)
			id_ex <= '0;
		else
			id_ex <= id_ex_next;
	end

endmodule

/* src/execute_stage.sv */
// branches resolve here, a load result is never forwarded from mem (decode stalls for it)
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
	input  logic      clk,
	input  logic      proc_reset,
	input  id_ex_t    id_ex,
	output ex_mem_t   ex_mem,
	input  wb_t       wb,
	output redirect_t redirect
);

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] rs2_val;	// forwarded rs2, also the store data
	logic [xlen-1:0] op_b;
	logic [4:0]      shamt;
	logic [xlen-1:0] alu_out;
	ex_mem_t         ex_mem_next;

	// nearest producer first, x0 never forwards
	function automatic logic [xlen-1:0] fwd(
		input logic [reg_addr_w-1:0] src,
		input logic [xlen-1:0]       reg_val,
		input ex_mem_t               mem_q,
		input wb_t                   wb_in
	);
		if (src != '0 && mem_q.ctrl.reg_write && !mem_q.ctrl.mem_read && mem_q.rd == src)
			return mem_q.alu_result;
		if (src != '0 && wb_in.reg_write && wb_in.rd == src)
			return wb_in.data;
		return reg_val;
	endfunction

	// --------------------
	// operands and alu
	always_comb begin
		op_a    = fwd(id_ex.rs1, id_ex.rs1_data, ex_mem, wb);
		rs2_val = fwd(id_ex.rs2, id_ex.rs2_data, ex_mem, wb);
		op_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_val;
		shamt   = op_b[4:0];
		case (id_ex.alu_op)
			alu_add: alu_out = op_a + op_b;
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or:  alu_out = op_a | op_b;
			alu_xor: alu_out = op_a ^ op_b;
			alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_sll: alu_out = op_a << shamt;
			alu_srl: alu_out = op_a >> shamt;
			alu_sra: alu_out = $unsigned($signed(op_a) >>> shamt);	// sign fill
			default: alu_out = op_a + op_b;
		endcase
	end

	// branch compare on forwarded regs, target is pc relative
	always_comb begin
		redirect.taken = (id_ex.ctrl.is_beq && op_a == rs2_val) ||
			(id_ex.ctrl.is_bne && op_a != rs2_val);
		redirect.target = id_ex.pc + id_ex.imm;
	end

	// --------------------
	// ex/mem register
	always_comb begin
		ex_mem_next.ctrl       = id_ex.ctrl;
		ex_mem_next.rd         = id_ex.rd;
		ex_mem_next.alu_result = alu_out;
		ex_mem_next.store_data = rs2_val;
	end

	always_ff @(posedge clk) begin
		if (proc_reset)
			ex_mem <= '0;	// bubble
		else
			ex_mem <= ex_mem_next;
	end

endmodule

/* src/mem_wb_stage.sv */
// dmem is a synchronous word port, read data must arrive on the edge after dmem_read
`timescale 1ns/1ps

module mem_wb_stage import rv_pkg::*; (
	input  logic              clk,
	input  logic              proc_reset,
	input  ex_mem_t           ex_mem,
	output logic              dmem_read,
	output logic              dmem_write,
	output logic [addr_w-1:0] dmem_addr,
	output logic [xlen-1:0]   dmem_wdata,
	input  logic [xlen-1:0]   dmem_rdata,
	output wb_t               wb
);

	wb_t  wb_q;	// alu result path
	logic load_q;	// take dmem_rdata instead

	// strobes straight from the mem-stage ctrl, bubbles keep them low
	assign dmem_read  = ex_mem.ctrl.mem_read;
	assign dmem_write = ex_mem.ctrl.mem_write;
	assign dmem_addr  = ex_mem.alu_result[xlen-1:2];	// drop byte offset
	assign dmem_wdata = ex_mem.store_data;

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			wb_q   <= '0;
			load_q <= 1'b0;
		end else begin
			wb_q.reg_write <= ex_mem.ctrl.reg_write;
			wb_q.rd        <= ex_mem.rd;
			wb_q.data      <= ex_mem.alu_result;
			load_q         <= ex_mem.ctrl.mem_read;
		end
	end

	// load data lands this cycle, pick it late
	always_comb begin
		wb = wb_q;
		if (load_q)
			wb.data = dmem_rdata;
	end

endmodule

/* src/rv_pipeline_top.sv */
// five-stage pipeline, both memory ports are one-cycle synchronous and never stall
`timescale 1ns/1ps

module rv_pipeline_top import rv_pkg::*; (
	input  logic              clk,
	input  logic              proc_reset,
	// instruction port
	output logic [addr_w-1:0] imem_addr,
	input  logic [xlen-1:0]   imem_rdata,
	// data port
	output logic              dmem_read,
	output logic              dmem_write,
	output logic [addr_w-1:0] dmem_addr,
	output logic [xlen-1:0]   dmem_wdata,
	input  logic [xlen-1:0]   dmem_rdata
);

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	wb_t       wb;
	redirect_t redirect;	// from ex to fetch and decode
	logic      stall;	// load-use

	fetch_stage u_fetch (
		.clk        (clk),
		.proc_reset (proc_reset),
		.stall      (stall),
		.redirect   (redirect),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.if_id      (if_id)
	);

	decode_stage u_decode (
		.clk        (clk),
		.proc_reset (proc_reset),
		.if_id      (if_id),
		.wb         (wb),
		.redirect   (redirect),
		.stall      (stall),
		.id_ex      (id_ex)
	);

	execute_stage u_execute (
		.clk        (clk),
		.proc_reset (proc_reset),
		.id_ex      (id_ex),
		.ex_mem     (ex_mem),
		.wb         (wb),
		.redirect   (redirect)
	);

	mem_wb_stage u_mem_wb (
		.clk        (clk),
		.proc_reset (proc_reset),
		.ex_mem     (ex_mem),
		.dmem_read  (dmem_read),
		.dmem_write (dmem_write),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.wb         (wb)
	);

endmodule

/* bench/rv_pipeline_props.sv */
// bound into every mem_wb_stage and expects the lw and sw ctrl encodings from decode
`timescale 1ns/1ps

module rv_pipeline_props import rv_pkg::*; (
	input logic    clk,
	input logic    proc_reset,
	input ex_mem_t ex_mem,
	input logic    dmem_read,
	input logic    dmem_write
);

	// one strobe at a time
	one_strobe: assert property (@(posedge clk) disable iff (proc_reset)
		!(dmem_read && dmem_write))
		else $error("dmem_read and dmem_write high together");

	// first cycle out of reset is quiet
	reset_quiet: assert property (@(posedge clk) proc_reset |=> !dmem_read && !dmem_write)
		else $error("memory strobe raised right after proc_reset");

	// strobes need a whole lw or sw ctrl and never fire for a bubble
	bubble_quiet: assert property (@(posedge clk) disable iff (proc_reset)
		(dmem_read || dmem_write) |->
			(ex_mem.ctrl == 6'b110100 || ex_mem.ctrl == 6'b001100))	// lw or sw
		else $error("memory strobe raised without a full lw or sw ctrl");

endmodule

bind mem_wb_stage rv_pipeline_props u_props (
	.clk        (clk),
	.proc_reset (proc_reset),
	.ex_mem     (ex_mem),
	.dmem_read  (dmem_read),
	.dmem_write (dmem_write)
);

/* bench/rv_pipeline_tb.sv */
// imem and dmem models hold 256 words each and only the order of stores is checked
`timescale 1ns/1ps

module rv_pipeline_tb import rv_pkg::*; ();

	logic              clk = 1'b0;
	logic              proc_reset;
	logic [addr_w-1:0] imem_addr;
	logic [xlen-1:0]   imem_rdata;
	logic              dmem_read;
	logic              dmem_write;
	logic [addr_w-1:0] dmem_addr;
	logic [xlen-1:0]   dmem_wdata;
	logic [xlen-1:0]   dmem_rdata;

	logic [xlen-1:0] imem [0:255];
	logic [xlen-1:0] dmem [0:255];

	// one table row per program
	// rows are split by the first-index queues
	logic [xlen-1:0]   prog_q [$];
	logic [addr_w-1:0] exp_addr_q [$];
	logic [xlen-1:0]   exp_data_q [$];
	int                prog_first [$];
	int                exp_first [$];

	int errors  = 0;
	int checked = 0;
	int exp_idx = 0;	// next expected store
	int exp_end = 0;
	int cycles  = 0;
	int limit   = 0;

	rv_pipeline_top UUT (
		.clk        (clk),
		.proc_reset (proc_reset),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_read  (dmem_read),
		.dmem_write (dmem_write),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata)
	);

	always #2 clk = ~clk;	// 4 ns

	// --------------------
	// one-cycle synchronous memory models
	always @(posedge clk) begin
		imem_rdata <= imem[imem_addr[7:0]];
		if (dmem_read)
			dmem_rdata <= dmem[dmem_addr[7:0]];	// only on the read strobe
		if (dmem_write)
			dmem[dmem_addr[7:0]] <= dmem_wdata;	// lands at this edge
	end

	// stores checked in order against the table
	always @(posedge clk) begin
		if (!proc_reset && dmem_write) begin
			if (exp_idx >= exp_end) begin
				$display("unexpected extra store at %0t ns to word %h", $time, dmem_addr);
				errors++;
			end else begin
				if (dmem_addr !== exp_addr_q[exp_idx]) begin
					$display("** Error at %0t ns: dmem_addr = %h, expected %h",
						$time, dmem_addr, exp_addr_q[exp_idx]);
					errors++;
				end
				if (dmem_wdata !== exp_data_q[exp_idx]) begin
					$display("** Error at %0t ns: dmem_wdata = %h, expected %h",
						$time, dmem_wdata, exp_data_q[exp_idx]);
					errors++;
				end
				exp_idx++;
				checked++;
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, the programs did not finish", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// --------------------
	// instruction encoders
	function automatic logic [31:0] arith_rr(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] arith_ri(input int f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
	endfunction

	function automatic logic [31:0] load(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic logic [31:0] store(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			7'b1100011};
	endfunction

	// data image where every word differs
	function automatic logic [31:0] fill_word(input logic [addr_w-1:0] a);
		return ({2'b00, a} * 32'h9e37_79b1) ^ 32'h1234_5678;
	endfunction

	task automatic open_row();
		prog_first.push_back(prog_q.size());
		exp_first.push_back(exp_data_q.size());
	endtask

	task automatic emit(input logic [31:0] w);
		prog_q.push_back(w);
	endtask

	task automatic expect_store(input int word, input logic [31:0] value);
		exp_addr_q.push_back(word[addr_w-1:0]);
		exp_data_q.push_back(value);
	endtask

	// reset and load, then run until fetch is well past the program
	task automatic run_row(input int row);
		int first;
		int len;
		first = prog_first[row];
		len   = prog_first[row+1] - first;
		@(posedge clk);
		proc_reset <= 1'b1;
		repeat (7) @(posedge clk);
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] <= (i < len) ? prog_q[first+i] : nop_instr;
			dmem[i[7:0]] <= fill_word(i[addr_w-1:0]);
		end
		exp_idx = exp_first[row];
		exp_end = exp_first[row+1];
		@(negedge clk);
		if (imem_addr !== '0) begin
			$display("** Error at %0t ns: imem_addr = %h, expected 0", $time, imem_addr);
			errors++;
		end
		if (dmem_read !== 1'b0 || dmem_write !== 1'b0) begin
			$display("** Error at %0t ns: dmem_read/dmem_write = %b%b, expected 00",
				$time, dmem_read, dmem_write);
			errors++;
		end
		@(posedge clk);
		proc_reset <= 1'b0;
		while (int'(imem_addr) < len + 6)
			@(negedge clk);
		repeat (4) @(negedge clk);	// drain
		if (exp_idx != exp_end) begin
			$display("program %0d never made %0d of its expected stores", row, exp_end - exp_idx);
			errors++;
		end
	endtask

	initial begin
		proc_reset <= 1'b1;
		imem_rdata <= '0;
		dmem_rdata <= '0;

		// register alu ops
		open_row();
		emit(arith_ri(0, 1, 0, -7));	// x1 = -7
		emit(arith_ri(0, 2, 0, 12));
		emit(arith_rr(0, 0, 3, 1, 2));	// add
		emit(arith_rr(32, 0, 4, 1, 2));	// sub
		emit(arith_rr(0, 7, 5, 1, 2));	// and
		emit(arith_rr(0, 6, 6, 1, 2));	// or
		emit(arith_rr(0, 4, 7, 1, 2));	// xor
		emit(arith_rr(0, 2, 8, 1, 2));	// slt signed true
		emit(arith_rr(0, 2, 9, 2, 1));	// slt false
		for (int r = 3; r <= 9; r++)
			emit(store(r, 0, 'h100 + 4 * (r - 3)));
		expect_store(64, 32'd5);
		expect_store(65, 32'hffff_ffed);
		expect_store(66, 32'h0000_0008);
		expect_store(67, 32'hffff_fffd);
		expect_store(68, 32'hffff_fff5);
		expect_store(69, 32'd1);
		expect_store(70, 32'd0);

		// immediate alu ops
		open_row();
		emit(arith_ri(0, 1, 0, -100));	// 0xffffff9c
		emit(arith_ri(7, 2, 1, 'hf0));	// andi
		emit(arith_ri(6, 3, 1, 'h123));	// ori
		emit(arith_ri(4, 4, 1, -1));	// xori as not
		emit(arith_ri(2, 5, 1, -99));	// slti true
		emit(arith_ri(2, 6, 1, -100));	// slti equal
		emit(arith_ri(1, 7, 1, 4));	// slli
		emit(arith_ri(5, 8, 1, 28));	// srli
		emit(arith_ri(5, 9, 1, 'h402));	// srai by 2
		emit(arith_ri(0, 10, 1, 300));
		for (int r = 2; r <= 10; r++)
			emit(store(r, 0, 'h120 + 4 * (r - 2)));
		expect_store(72, 32'h0000_0090);
		expect_store(73, 32'hffff_ffbf);
		expect_store(74, 32'h0000_0063);
		expect_store(75, 32'd1);
		expect_store(76, 32'd0);
		expect_store(77, 32'hffff_f9c0);
		expect_store(78, 32'h0000_000f);
		expect_store(79, 32'hffff_ffe7);
		expect_store(80, 32'd200);

		// back-to-back chains through mem and wb forwarding
		open_row();
		emit(arith_ri(0, 1, 0, 5));
		emit(arith_ri(0, 2, 1, 3));	// 8
		emit(arith_rr(0, 0, 3, 2, 1));	// 13
		emit(arith_rr(32, 0, 4, 3, 2));	// 5
		emit(arith_rr(0, 4, 5, 4, 3));	// 8
		emit(store(5, 0, 'h160));	// store data from mem stage
		emit(store(4, 0, 'h164));
		emit(arith_rr(0, 0, 6, 5, 5));	// 16
		emit(arith_ri(0, 7, 0, 'h40));
		emit(store(6, 7, 8));	// base forwarded
		expect_store(88, 32'd8);
		expect_store(89, 32'd5);
		expect_store(18, 32'd16);

		// load-use bubbles
		open_row();
		emit(arith_ri(0, 3, 0, 7));
		emit(load(1, 0, 'h20));
		emit(arith_rr(0, 0, 2, 1, 3));	// needs the load
		emit(store(2, 0, 'h180));
		emit(load(4, 0, 'h24));
		emit(store(4, 0, 'h184));	// load into store data
		emit(store(2, 0, 'h188));
		emit(load(5, 0, 'h188));	// reads the word just stored
		emit(arith_ri(0, 5, 5, 1));
		emit(store(5, 0, 'h18c));
		expect_store(96, fill_word(30'd8) + 32'd7);
		expect_store(97, fill_word(30'd9));
		expect_store(98, fill_word(30'd8) + 32'd7);
		expect_store(99, fill_word(30'd8) + 32'd8);

		// taken branches drop the next two stores
		open_row();
		emit(arith_ri(0, 1, 0, 3));
		emit(arith_ri(0, 2, 0, 3));
		emit(branch(0, 1, 2, 12));	// beq taken
		emit(store(1, 0, 'h1a0));
		emit(store(2, 0, 'h1a4));
		emit(store(1, 0, 'h1a8));
		emit(branch(1, 1, 2, 12));	// bne not taken
		emit(store(1, 0, 'h1ac));
		emit(store(2, 0, 'h1b0));
		emit(arith_ri(0, 3, 0, 9));
		emit(branch(1, 1, 3, 12));	// bne taken on forwarded x3
		emit(store(3, 0, 'h1b4));
		emit(store(3, 0, 'h1b8));
		emit(store(3, 0, 'h1bc));
		emit(branch(0, 1, 3, 8));	// beq not taken
		emit(store(1, 0, 'h1c0));
		expect_store(106, 32'd3);
		expect_store(107, 32'd3);
		expect_store(108, 32'd3);
		expect_store(111, 32'd9);
		expect_store(112, 32'd3);

		// x0 stays zero
		open_row();
		emit(arith_ri(0, 1, 0, 77));
		emit(arith_ri(0, 0, 0, 55));
		emit(store(0, 0, 'h1d0));
		emit(arith_rr(0, 0, 0, 1, 1));
		emit(arith_rr(0, 0, 3, 0, 1));	// 0 + 77
		emit(store(3, 0, 'h1d4));
		emit(store(0, 0, 'h1d8));
		expect_store(116, 32'd0);
		expect_store(117, 32'd77);
		expect_store(118, 32'd0);

		open_row();	// end marker
		limit = 8 * prog_q.size() + 200;

		for (int row = 0; row < prog_first.size() - 1; row++)
			run_row(row);

		$display("%0d errors, %0d stores checked over %0d programs",
			errors, checked, prog_first.size() - 1);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* files.f */
src/rv_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/rv_pipeline_top.sv
bench/rv_pipeline_props.sv
bench/rv_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module rv_pipeline_tb -f files.f \
	-o rv_pipeline_sim > build.log 2>&1 \
	&& ./obj_dir/rv_pipeline_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1
